// File: verification/echo.hex
// one 32-bit instruction word per line in hex, loaded from address 0
// echo-with-count program, assembly after each word
100100B7 // lui  x1, 0x10010       uart base.
00800113 // addi x2, x0, 8
1020A023 // sw   x2, 256(x1)       divisor = 8.
00002023 // sw   x0, 0(x0)         count = 0.
0050C183 // lbu  x3, 5(x1)         wait for read_ready.
0011F193 // andi x3, x3, 1
FE018CE3 // beq  x3, x0, -8
0000C203 // lbu  x4, 0(x1)         received byte.
00002283 // lw   x5, 0(x0)
00128293 // addi x5, x5, 1
00502023 // sw   x5, 0(x0)         count += 1.
0050C183 // lbu  x3, 5(x1)         wait while busy.
0401F193 // andi x3, x3, 64
FE019CE3 // bne  x3, x0, -8
00520333 // add  x6, x4, x5
0060A023 // sw   x6, 0(x1)         send byte + count.
FD1FF06F // jal  x0, -48

// File: src.f
verilog/soc_pkg.sv
verilog/rv_core.sv
verilog/imem.sv
verilog/dmem.sv
verilog/uart.sv
verilog/soc_top.sv
verification/soc_tb.sv

// File: Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -Wall -Wno-fatal
TOP      := soc_tb
FILELIST := src.f

SOURCES  := $(shell cat $(FILELIST))
BIN      := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: verification/soc_tb.sv
`default_nettype none
`timescale 1ns/100ps

module soc_tb;

    localparam int clks_per_bit = 8;    // rate set by the echo program.
    localparam int idle_cycles  = 200;
    localparam int frame_wait   = 2000; // cycles allowed before an echo starts.
    localparam int drain_wait   = 20;
    localparam int random_bytes = 20;

    typedef struct packed {
        logic [7:0] sent;
        logic [7:0] got;
        logic [7:0] count;
        logic       start_bit;
        logic       stop_bit;
    } echo_t;

    logic clk;
    logic rst;
    logic rx;
    logic tx;

    echo_t  echo_q [$];
    integer seed;
    int     pass_count;
    int     fail_count;
    int     pushed;
    int     compared;
    bit     aborted;

    soc_top u_soc_top (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .tx  (tx)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [7:0] expected_byte(input logic [7:0] b, input logic [7:0] k);
        int sum;
        sum = int'(b) + int'(k);
        return 8'(sum % 256);
    endfunction

    function automatic int zeros_before_first_one(input logic [7:0] b);
        int n;
        n = 0;
        while (n < 8 && b[n[2:0]] == 1'b0) begin
            n++;
        end
        return n;
    endfunction

    task automatic report_test(input string name, input bit ok);
        if (ok) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: FAILED", name);
        end
    endtask

    // start bit, eight data bits lsb first, stop bit.
    task automatic send_byte(input logic [7:0] b, input int bit_cycles);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            rx = frame[i];
            repeat (bit_cycles - 1) @(negedge clk);
        end
    endtask

    task automatic receive_frame(input int bit_cycles, output logic [7:0] data,
                                 output logic start_bit, output logic stop_bit,
                                 output int low_run, output bit timed_out);
        int waited;
        int last;
        int slot;
        bit in_low;
        waited    = 0;
        timed_out = 1'b0;
        data      = 8'h00;
        start_bit = 1'b1;
        stop_bit  = 1'b0;
        low_run   = 0;
        @(negedge clk);
        while (tx !== 1'b0) begin
            if (waited >= frame_wait) begin
                timed_out = 1'b1;
                return;
            end
            @(negedge clk);
            waited++;
        end
        in_low = 1'b1;
        last   = 9 * bit_cycles + bit_cycles / 2; // middle of the stop bit.
        for (int n = 0; n <= last; n++) begin
            if (in_low && tx === 1'b0) begin
                low_run++;
            end else begin
                in_low = 1'b0;
            end
            if (n % bit_cycles == bit_cycles / 2) begin
                slot = n / bit_cycles;
                if (slot == 0) begin
                    start_bit = tx;
                end else if (slot == 9) begin
                    stop_bit = tx;
                end else begin
                    data[3'(slot - 1)] = tx;
                end
            end
            if (n < last) begin
                @(negedge clk);
            end
        end
    endtask

    // the echo begins well after our stop bit, so send and listen in turn.
    task automatic run_echo(input logic [7:0] b, input logic [7:0] k,
                            output logic [7:0] got, output int low_run);
        echo_t rec;
        logic  start_bit;
        logic  stop_bit;
        bit    timed_out;
        send_byte(b, clks_per_bit);
        receive_frame(clks_per_bit, got, start_bit, stop_bit, low_run, timed_out);
        if (timed_out) begin
            $display("timeout: no start bit on tx within %0d cycles after sending echo %0d",
                     frame_wait, k);
            fail_count++;
            aborted = 1'b1;
        end else begin
            rec.sent      = b;
            rec.got       = got;
            rec.count     = k;
            rec.start_bit = start_bit;
            rec.stop_bit  = stop_bit;
            echo_q.push_back(rec);
            pushed++;
        end
    endtask

    always @(posedge clk) begin
        echo_t      rec;
        logic [7:0] expected;
        bit         ok;
        while (echo_q.size() > 0) begin
            rec      = echo_q.pop_front();
            expected = expected_byte(rec.sent, rec.count);
            ok       = 1'b1;
            if (rec.start_bit !== 1'b0 || rec.stop_bit !== 1'b1) begin
                $display("framing error on echo %0d: start bit was %b and stop bit was %b",
                         rec.count, rec.start_bit, rec.stop_bit);
                ok = 1'b0;
            end
            if (rec.got !== expected) begin
                $display("CHECK FAILED at %0t: echo %0d of byte %h returned %h, expected %h",
                         $time, rec.count, rec.sent, rec.got, expected);
                ok = 1'b0;
            end
            report_test($sformatf("echo %0d (sent %h, got %h)", rec.count, rec.sent, rec.got),
                        ok);
            compared++;
        end
    end

    initial begin
        logic [7:0] b;
        logic [7:0] got;
        int         low_run;
        int         start_len;
        int         lows;
        int         waited;
        seed       = 32'h483dd652;
        rst        = 1'b1;
        rx         = 1'b1;
        aborted    = 1'b0;
        pass_count = 0;
        fail_count = 0;
        pushed     = 0;
        compared   = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // also gives the program time to set the divisor.
        lows = 0;
        for (int i = 0; i < idle_cycles; i++) begin
            @(negedge clk);
            if (tx !== 1'b1) begin
                lows++;
            end
        end
        if (lows != 0) begin
            $display("CHECK FAILED at %0t: tx was low on %0d of the first %0d cycles",
                     $time, lows, idle_cycles);
        end
        report_test("idle tx after reset", lows == 0);

        run_echo(8'h41, 8'd1, got, low_run);
        if (!aborted) begin
            // split off the leading zeros of the expected echo.
            start_len = low_run / (1 + zeros_before_first_one(expected_byte(8'h41, 8'd1)));
            if (start_len < clks_per_bit - 1 || start_len > clks_per_bit + 1) begin
                $display("CHECK FAILED at %0t: start bit lasted %0d cycles, expected %0d",
                         $time, start_len, clks_per_bit);
            end
            report_test("start bit length",
                        start_len >= clks_per_bit - 1 && start_len <= clks_per_bit + 1);
        end

        for (int k = 2; k < random_bytes + 2; k++) begin
            if (!aborted) begin
                b = 8'($random(seed));
                run_echo(b, 8'(k), got, low_run);
            end
        end

        waited = 0;
        while (compared < pushed && waited < drain_wait) begin
            @(negedge clk);
            waited++;
        end
        if (compared < pushed) begin
            $display("timeout: compare process left %0d echoes unchecked", pushed - compared);
            fail_count++;
        end

        $display("tests run: %0d, passed: %0d, failed: %0d",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/soc_top.sv
`default_nettype none
`timescale 1ns/100ps

module soc_top import soc_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rx,
    output logic tx
);

    logic [31:0] pc;
    instr_t      instr;
    mem_req_t    mem_req;
    mem_req_t    dmem_req;
    logic [31:0] rdata;
    logic [31:0] dmem_rdata;

    logic [31:0] div;
    logic [7:0]  tx_holding;
    logic [7:0]  rx_holding;
    logic [7:0]  line_status;
    logic        tx_start;
    logic        read_ready;
    logic        busy;
    logic        rx_done;
    logic [7:0]  rx_byte;
    logic        data_sel;
    logic        div_sel;

    assign data_sel = (mem_req.addr == uart_data_addr);
    assign div_sel  = (mem_req.addr == uart_div_addr);

    always_comb begin
        dmem_req    = mem_req;
        dmem_req.we = mem_req.we && !data_sel; // uart data never lands in ram.
    end

    always_comb begin
        case (mem_req.addr)
            uart_data_addr:   rdata = {24'd0, rx_holding};
            uart_status_addr: rdata = {4{line_status}}; // any byte lane sees status.
            default:          rdata = dmem_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div         <= uart_div_reset;
            tx_start    <= 1'b0;
            read_ready  <= 1'b0;
            line_status <= 8'd0;
        end else begin
            tx_start <= mem_req.we && data_sel;
            if (mem_req.we && div_sel) begin
                div <= mem_req.wdata;
            end
            if (rx_done) begin
                read_ready <= 1'b1;
            end else if (data_sel && !mem_req.we) begin
                read_ready <= 1'b0;
            end
            line_status <= {1'b0, busy, 5'd0, read_ready}; // one cycle behind.
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.we && data_sel) begin
            tx_holding <= mem_req.wdata[7:0];
        end
        if (rx_done) begin
            rx_holding <= rx_byte;
        end
    end

    rv_core u_rv_core (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .instr   (instr),
        .mem_req (mem_req),
        .rdata   (rdata)
    );

    imem u_imem (
        .pc    (pc),
        .instr (instr)
    );

    dmem u_dmem (
        .clk   (clk),
        .req   (dmem_req),
        .rdata (dmem_rdata)
    );

    uart u_uart (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .rx       (rx),
        .tx_data  (tx_holding),
        .div      (div),
        .tx       (tx),
        .busy     (busy),
        .rx_done  (rx_done),
        .rx_byte  (rx_byte)
    );

endmodule

`default_nettype wire

// File: verilog/uart.sv
`default_nettype none
`timescale 1ns/100ps

module uart import soc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        tx_start,
    input  logic        rx,
    input  logic [7:0]  tx_data,
    input  logic [31:0] div,
    output logic        tx,
    output logic        busy,
    output logic        rx_done,
    output logic [7:0]  rx_byte
);

    logic [1:0]  tx_state;
    logic [31:0] tx_cnt;
    logic [31:0] tx_div;
    logic [7:0]  tx_shift;
    logic [2:0]  tx_bit;

    logic [1:0]  rx_state;
    logic [31:0] rx_cnt;
    logic [31:0] rx_div;
    logic [7:0]  rx_shift;
    logic [2:0]  rx_bit;
    logic        rx_s1;
    logic        rx_s2;
    logic        rx_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= st_idle;
            tx_cnt   <= 32'd0;
            tx_bit   <= 3'd0;
            tx       <= 1'b1;
            busy     <= 1'b0;
        end else begin
            case (tx_state)
                st_idle: begin
                    if (tx_start) begin
                        tx_shift <= tx_data;
                        tx_div   <= div;
                        tx_cnt   <= div - 32'd1;
                        tx       <= 1'b0; // start bit.
                        busy     <= 1'b1;
                        tx_state <= st_start;
                    end
                end
                st_start: begin
                    if (tx_cnt == 32'd0) begin
                        tx_cnt   <= tx_div - 32'd1;
                        tx       <= tx_shift[0];
                        tx_shift <= tx_shift >> 1;
                        tx_bit   <= 3'd0;
                        tx_state <= st_data;
                    end else begin
                        tx_cnt <= tx_cnt - 32'd1;
                    end
                end
                st_data: begin
                    if (tx_cnt == 32'd0) begin
                        tx_cnt <= tx_div - 32'd1;
                        if (tx_bit == 3'd7) begin
                            tx       <= 1'b1; // stop bit.
                            tx_state <= st_stop;
                        end else begin
                            tx       <= tx_shift[0];
                            tx_shift <= tx_shift >> 1;
                            tx_bit   <= tx_bit + 3'd1;
                        end
                    end else begin
                        tx_cnt <= tx_cnt - 32'd1;
                    end
                end
                default: begin
                    if (tx_cnt == 32'd0) begin
                        busy     <= 1'b0;
                        tx_state <= st_idle;
                    end else begin
                        tx_cnt <= tx_cnt - 32'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            rx_prev  <= 1'b1;
            rx_state <= st_idle;
            rx_cnt   <= 32'd0;
            rx_bit   <= 3'd0;
            rx_done  <= 1'b0;
        end else begin
            rx_s1   <= rx;
            rx_s2   <= rx_s1;
            rx_prev <= rx_s2;
            rx_done <= 1'b0;
            case (rx_state)
                st_idle: begin
                    if (rx_prev && !rx_s2) begin
                        rx_div   <= div;
                        rx_cnt   <= (div >> 1) - 32'd1; // half a bit to mid-start.
                        rx_state <= st_start;
                    end
                end
                st_start: begin
                    if (rx_cnt == 32'd0) begin
                        if (!rx_s2) begin
                            rx_cnt   <= rx_div - 32'd1;
                            rx_bit   <= 3'd0;
                            rx_state <= st_data;
                        end else begin
                            rx_state <= st_idle; // glitch, not a start bit.
                        end
                    end else begin
                        rx_cnt <= rx_cnt - 32'd1;
                    end
                end
                st_data: begin
                    if (rx_cnt == 32'd0) begin
                        rx_shift <= {rx_s2, rx_shift[7:1]};
                        rx_cnt   <= rx_div - 32'd1;
                        if (rx_bit == 3'd7) begin
                            rx_state <= st_stop;
                        end else begin
                            rx_bit <= rx_bit + 3'd1;
                        end
                    end else begin
                        rx_cnt <= rx_cnt - 32'd1;
                    end
                end
                default: begin
                    if (rx_cnt == 32'd0) begin
                        if (rx_s2) begin
                            rx_byte <= rx_shift;
                            rx_done <= 1'b1;
                        end
                        rx_state <= st_idle;
                    end else begin
                        rx_cnt <= rx_cnt - 32'd1;
                    end
                end
            endcase
        end
    end

    // software polls busy, so a new frame never overlaps the last one.
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) tx_start |-> !busy);

endmodule

`default_nettype wire

// File: verilog/dmem.sv
`default_nettype none
`timescale 1ns/100ps

module dmem import soc_pkg::*; (
    input  logic        clk,
    input  mem_req_t    req,
    output logic [31:0] rdata
);

    logic [31:0] ram [dmem_words];
    logic [dmem_aw-1:0] word_idx;

    assign word_idx = req.addr[dmem_aw+1:2]; // wraps at dmem_words.

    always_ff @(posedge clk) begin
        if (req.we) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wmask[i]) begin
                    ram[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    assign rdata = ram[word_idx];

endmodule

`default_nettype wire

// File: verilog/imem.sv
`default_nettype none
`timescale 1ns/100ps

module imem import soc_pkg::*; (
    input  logic [31:0] pc,
    output instr_t      instr
);

    logic [31:0] rom [imem_words];
    logic [imem_aw-1:0] word_idx;

    initial begin
        $readmemh("verification/echo.hex", rom);
    end

    assign word_idx = pc[imem_aw+1:2]; // drop the byte offset.
    assign instr    = rom[word_idx];

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core import soc_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic [31:0] pc,
    input  instr_t      instr,
    output mem_req_t    mem_req,
    input  logic [31:0] rdata
);

    logic [31:0] regs [32];

    logic [6:0]  opcode;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic [31:0] ea;
    logic [31:0] load_val;
    logic [31:0] wb_val;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic        is_load;
    logic        is_store;
    logic        rd_we;
    logic        taken;

    // one instruction word seen through each of its formats.
    assign opcode = instr.r_fmt.opcode;
    assign rs1    = instr.r_fmt.rs1;
    assign rs2    = instr.r_fmt.rs2;
    assign rd     = instr.r_fmt.rd;
    assign funct3 = instr.r_fmt.funct3;
    assign funct7 = instr.r_fmt.funct7;

    assign imm_i = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm20, 12'b0};
    // jal shuffles its immediate inside the u-format field.
    assign imm_j = {{11{instr.u_fmt.imm20[19]}}, instr.u_fmt.imm20[19],
                    instr.u_fmt.imm20[7:0], instr.u_fmt.imm20[8],
                    instr.u_fmt.imm20[18:9], 1'b0};

    assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1]; // x0 reads as zero.
    assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

    assign is_load  = (opcode == op_load);
    assign is_store = (opcode == op_store);
    assign pc_plus4 = pc + 32'd4;

    assign alu_b = (opcode == op_op) ? rs2_val : imm_i;

    always_comb begin
        case (funct3)
            f3_add: begin
                if (opcode == op_op && funct7 == f7_sub) begin
                    alu_out = rs1_val - alu_b;
                end else begin
                    alu_out = rs1_val + alu_b;
                end
            end
            f3_sll:  alu_out = rs1_val << alu_b[4:0];
            f3_srl:  alu_out = rs1_val >> alu_b[4:0];
            f3_xor:  alu_out = rs1_val ^ alu_b;
            f3_or:   alu_out = rs1_val | alu_b;
            f3_and:  alu_out = rs1_val & alu_b;
            default: alu_out = rs1_val + alu_b;
        endcase
    end

    always_comb begin
        case (funct3)
            f3_beq:  taken = (rs1_val == rs2_val);
            f3_bne:  taken = (rs1_val != rs2_val);
            f3_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
            f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            default: taken = 1'b0;
        endcase
    end

    assign ea = rs1_val + (is_store ? imm_s : imm_i);

    // address stays at zero when there is no access, so no i/o read fires.
    always_comb begin
        mem_req.addr  = (is_load || is_store) ? ea : 32'd0;
        mem_req.we    = is_store;
        mem_req.wdata = rs2_val;
        mem_req.wmask = 4'b0000;
        if (is_store) begin
            if (funct3 == f3_byte) begin
                mem_req.wdata = {4{rs2_val[7:0]}}; // byte goes on every lane.
                mem_req.wmask = 4'b0001 << ea[1:0];
            end else begin
                mem_req.wmask = 4'b1111;
            end
        end
    end

    always_comb begin
        if (funct3 == f3_ubyte) begin
            load_val = {24'd0, rdata[8*ea[1:0] +: 8]};
        end else begin
            load_val = rdata;
        end
    end

    always_comb begin
        rd_we  = 1'b1;
        wb_val = alu_out;
        case (opcode)
            op_lui:             wb_val = imm_u;
            op_op_imm, op_op:   wb_val = alu_out;
            op_load:            wb_val = load_val;
            op_jal, op_jalr:    wb_val = pc_plus4;
            default:            rd_we = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            op_jal:    next_pc = pc + imm_j;
            op_jalr:   next_pc = (rs1_val + imm_i) & ~32'd1;
            op_branch: next_pc = taken ? pc + imm_b : pc_plus4;
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 32'd0;
        end else begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_we && rd != 5'd0) begin
            regs[rd] <= wb_val;
        end
    end

    // jump and branch targets must keep fetch on word boundaries.
    a_pc_aligned: assert property (@(posedge clk) !rst |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/soc_pkg.sv
`default_nettype none

package soc_pkg;

    localparam logic [31:0] uart_data_addr   = 32'h10010000;
    localparam logic [31:0] uart_status_addr = 32'h10010005;
    localparam logic [31:0] uart_div_addr    = 32'h10010100;
    localparam logic [31:0] uart_div_reset   = 32'd16;       // clocks per bit after reset.

    localparam int imem_words = 64;
    localparam int dmem_words = 256;
    localparam int imem_aw    = $clog2(imem_words);
    localparam int dmem_aw    = $clog2(dmem_words);

    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_op_imm = 7'b0010011;
    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    localparam logic [2:0] f3_add   = 3'b000;
    localparam logic [2:0] f3_sll   = 3'b001;
    localparam logic [2:0] f3_xor   = 3'b100;
    localparam logic [2:0] f3_srl   = 3'b101;
    localparam logic [2:0] f3_or    = 3'b110;
    localparam logic [2:0] f3_and   = 3'b111;
    localparam logic [2:0] f3_beq   = 3'b000;
    localparam logic [2:0] f3_bne   = 3'b001;
    localparam logic [2:0] f3_blt   = 3'b100;
    localparam logic [2:0] f3_bge   = 3'b101;
    localparam logic [2:0] f3_byte  = 3'b000;
    localparam logic [2:0] f3_word  = 3'b010;
    localparam logic [2:0] f3_ubyte = 3'b100;
    localparam logic [6:0] f7_sub   = 7'b0100000;

    // serial state codes, shared by the tx and rx machines.
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wmask;
        logic        we;
    } mem_req_t;

endpackage

`default_nettype wire
